/* mipsLite.f */
+incdir+design
design/mipsLitePkg.sv
design/controlUnit.sv
design/alu.sv
design/regFile.sv
design/wbDataPort.sv
design/mipsLite.sv
tests/mipsLite_assert.sv
tests/mipsLiteTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the mipsLite testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --timescale 1ns/100ps \
  -f mipsLite.f \
  --top-module mipsLiteTb \
  --Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

simOut="$(./obj_dir/VmipsLiteTb 2>&1)"
simStatus=$?
echo "$simOut"

if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if echo "$simOut" | grep -qx "TEST RESULT: PASS"; then
  exit 0
fi
exit 1

/* tests/mipsLiteTb.sv */
// program of 27 words at address 0; data memory of 64 words, acks after 1 to 4 wait cycles.
`timescale 1ns/100ps
`include "mipsLite_defs.svh"

module mipsLiteTb;
  localparam int PROG_LEN = 27;
  localparam int N_STORES = 11;
  localparam int N_ACKS = 14; // 3 loads and 11 stores.
  localparam int CYCLE_LIMIT = 8 * PROG_LEN + 16;

  logic clk, arstN, wbCyc, wbStb, wbWe, wbAck;
  logic [31:0] instrAddr, instr, wbAdr, wbDatW, wbDatR;
  logic [3:0] wbSel;
  logic [31:0] prog [PROG_LEN];
  logic [31:0] mem [64];
  logic [31:0] expAdr [N_STORES];
  logic [31:0] expDat [N_STORES];
  logic [31:0] wrAdr [$];
  logic [31:0] wrDat [$];
  logic [31:0] rngState = 32'hc76d4bf0;
  logic [31:0] prevPc, seqPc, target, prevInstr, valA, valB, valC;
  int errors = 0, testsFailed = 0, mark = 0, cycles = 0, ackCount = 0;
  int waitSeen = 0, waitLen = 1;
  bit takenSeen = 0;

  mipsLite i_dut (.clk(clk), .arstN(arstN), .instrAddr(instrAddr), .instr(instr),
    .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatW(wbDatW),
    .wbSel(wbSel), .wbDatR(wbDatR), .wbAck(wbAck));

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [31:0] rType(input logic [4:0] rs, rt, rd, input logic [5:0] fn);
    return {`MIPS_OP_RTYPE, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs, rt,
                                        input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] fetch(input logic [31:0] addr);
    return (addr[31:2] < PROG_LEN) ? prog[addr[6:2]] : 32'h0; // zero decodes as no-op.
  endfunction

  always_comb instr = fetch(instrAddr);

  task automatic checkValue(input string name, input logic [31:0] got, exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic endTest(input string name);
    if (errors != mark) testsFailed++;
    $display("test %-16s %s", name, (errors == mark) ? "ok" : "failed");
    mark = errors;
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ##################################################
  // data memory slave, ack registered on the falling edge
  always @(negedge clk) begin
    if (!arstN) begin
      wbAck <= 1'b0;
    end else if (wbAck) begin
      wbAck <= 1'b0; // taken at the last rising edge.
      waitSeen = 0;
    end else if (wbStb) begin
      if (waitSeen >= waitLen) begin
        checkValue("wbCyc", {31'h0, wbCyc}, 32'h1);
        checkValue("wbSel", {28'h0, wbSel}, 32'hf);
        wbAck <= 1'b1;
        wbDatR <= mem[wbAdr[7:2]];
        ackCount++;
        if (wbWe) begin
          mem[wbAdr[7:2]] = wbDatW;
          wrAdr.push_back(wbAdr);
          wrDat.push_back(wbDatW);
        end
        waitSeen = 0;
        rngState = xorshift(rngState);
        waitLen = int'(rngState[1:0]) + 1;
      end else begin
        waitSeen++;
      end
    end
  end

  // pc trace, every change must be pc+4 or a beq target.
  always @(negedge clk) begin
    if (arstN && (instrAddr != prevPc)) begin
      prevInstr = fetch(prevPc);
      seqPc = prevPc + 32'd4;
      target = seqPc + {{14{prevInstr[15]}}, prevInstr[15:0], 2'b00};
      if (prevInstr[31:26] == `MIPS_OP_BEQ && instrAddr == target && target != seqPc) begin
        takenSeen = 1;
      end else if (instrAddr != seqPc) begin
        $display("[FAIL] instrAddr got 0x%08h expected 0x%08h", instrAddr, seqPc);
        errors++;
      end
      prevPc = instrAddr;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the program did not finish", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    arstN = 1'b0;
    wbAck = 1'b0;
    wbDatR = 32'h0;
    prevPc = 32'h0;
    valA = 32'h0000_1234;
    valB = 32'hffff_ff00; // negative for slt.
    valC = 32'h0f0f_00ff;
    for (int i = 0; i < 64; i++) mem[i] = 32'ha5a5_0000 ^ (32'(i) * 32'h0101_0101);
    mem[0] = valA;
    mem[1] = valB;
    mem[2] = valC;
    prog = '{32'h0,
      iType(`MIPS_OP_LW, 0, 1, 16'h0), iType(`MIPS_OP_LW, 0, 2, 16'h4),
      iType(`MIPS_OP_LW, 0, 3, 16'h8),
      rType(1, 3, 4, `MIPS_FN_ADD), iType(`MIPS_OP_SW, 0, 4, 16'h40),
      rType(1, 2, 5, `MIPS_FN_SUB), iType(`MIPS_OP_SW, 0, 5, 16'h44),
      rType(2, 3, 6, `MIPS_FN_AND), iType(`MIPS_OP_SW, 0, 6, 16'h48),
      rType(1, 2, 7, `MIPS_FN_OR), iType(`MIPS_OP_SW, 0, 7, 16'h4c),
      rType(2, 1, 8, `MIPS_FN_SLT), iType(`MIPS_OP_SW, 0, 8, 16'h50),
      rType(1, 2, 9, `MIPS_FN_SLT), iType(`MIPS_OP_SW, 0, 9, 16'h54),
      rType(1, 3, 0, `MIPS_FN_ADD), iType(`MIPS_OP_SW, 0, 0, 16'h58),
      iType(`MIPS_OP_SW, 0, 2, 16'h5c),
      iType(`MIPS_OP_BEQ, 1, 1, 16'h1), iType(`MIPS_OP_SW, 0, 1, 16'h60),
      iType(`MIPS_OP_BEQ, 1, 2, 16'h1), iType(`MIPS_OP_SW, 0, 3, 16'h64),
      iType(6'h3f, 0, 1, 16'h77), rType(2, 3, 4, 6'h3f),
      iType(`MIPS_OP_SW, 0, 1, 16'h68), iType(`MIPS_OP_SW, 0, 4, 16'h6c)};
    expAdr = '{32'h40, 32'h44, 32'h48, 32'h4c, 32'h50, 32'h54, 32'h58, 32'h5c,
      32'h64, 32'h68, 32'h6c};
    expDat = '{valA + valC, valA - valB, valB & valC, valA | valB,
      ($signed(valB) < $signed(valA)) ? 32'h1 : 32'h0,
      ($signed(valA) < $signed(valB)) ? 32'h1 : 32'h0,
      32'h0, valB, valC, valA, valA + valC};

    // ##################################################
    // reset
    repeat (16) begin
      @(negedge clk);
      checkValue("wbCyc", {31'h0, wbCyc}, 32'h0);
      checkValue("wbStb", {31'h0, wbStb}, 32'h0);
      checkValue("wbWe", {31'h0, wbWe}, 32'h0);
      checkValue("instrAddr", instrAddr, 32'h0);
    end
    arstN = 1'b1;
    @(negedge clk);
    checkValue("instrAddr", instrAddr, 32'h4); // first fetch at 0 is a no-op.
    endTest("reset");

    while (ackCount < N_ACKS) @(negedge clk);
    repeat (8) @(negedge clk);

    checkValue("write count", 32'(wrAdr.size()), 32'(N_STORES));
    for (int i = 0; i < N_STORES && i < wrAdr.size(); i++) begin
      checkValue($sformatf("wbAdr[%0d]", i), wrAdr[i], expAdr[i]);
      checkValue($sformatf("wbDatW[%0d]", i), wrDat[i], expDat[i]);
    end
    checkValue("bus accesses", 32'(ackCount), 32'(N_ACKS));
    endTest("stores");

    foreach (wrAdr[i]) begin
      if (wrAdr[i] == 32'h60) begin
        $display("store after a taken beq was executed");
        errors++;
      end
    end
    if (!takenSeen) begin
      $display("taken beq never changed the pc to its target");
      errors++;
    end
    endTest("branch");
    checkValue("wbCyc", {31'h0, wbCyc}, 32'h0);
    endTest("bus idle");

    $display("%0d tests run, %0d failed, %0d failed checks", 4, testsFailed, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* tests/mipsLite_assert.sv */
// wishbone protocol and reset checks bound to mipsLite; sampled at the rising clock edge.
`timescale 1ns/100ps

module mipsLite_assert (
  input logic clk,
  input logic arstN,
  input logic wbCyc,
  input logic wbStb,
  input logic wbWe,
  input logic [31:0] wbAdr,
  input logic [31:0] wbDatW,
  input logic wbAck
);

  // ##################################################
  // bus protocol
  ackInCycle: assert property (@(posedge clk) disable iff (!arstN)
    wbAck |-> (wbCyc && wbStb))
    else $error("wbAck high outside a bus cycle");

  holdUntilAck: assert property (@(posedge clk) disable iff (!arstN)
    (wbStb && !wbAck) |=> ($stable(wbAdr) && $stable(wbWe) && $stable(wbDatW)))
    else $error("wbAdr, wbWe or wbDatW changed before ack");

  // reset state.
  weLowInReset: assert property (@(posedge clk) !arstN |-> !wbWe)
    else $error("wbWe high during reset");

endmodule

bind mipsLite mipsLite_assert uAssert (
  .clk(clk),
  .arstN(arstN),
  .wbCyc(wbCyc),
  .wbStb(wbStb),
  .wbWe(wbWe),
  .wbAdr(wbAdr),
  .wbDatW(wbDatW),
  .wbAck(wbAck)
);

/* design/mipsLite.sv */
// single-cycle mips subset core; the instruction port must answer combinationally, one instruction in flight.
`timescale 1ns/100ps
`include "mipsLite_defs.svh"

module mipsLite import mipsLitePkg::*; (
  input logic clk,
  input logic arstN,
  output word_t instrAddr,
  input word_t instr,
  output logic wbCyc,
  output logic wbStb,
  output logic wbWe,
  output word_t wbAdr,
  output word_t wbDatW,
  output logic [3:0] wbSel,
  input word_t wbDatR,
  input logic wbAck
);

  word_t pc;
  word_t pcPlus4;
  word_t branchTarget;
  word_t pcNext;

  opcode_t opcode;
  funct_t funct;
  regAddr_t rs;
  regAddr_t rt;
  regAddr_t rd;
  word_t signImm;

  logic regWrite;
  logic regDst;
  logic aluSrc;
  logic branch;
  logic memWrite;
  logic memRead;
  logic memToReg;
  aluCtrl_t aluCtrl;

  word_t rdDataA;
  word_t rdDataB;
  word_t srcB;
  word_t aluResult;
  logic zero;
  regAddr_t writeReg;
  word_t writeData;
  word_t loadData;
  logic stall;

  // ##################################################
  // fetch and decode fields
  assign instrAddr = pc;
  assign opcode = instr[31:26];
  assign rs = instr[25:21];
  assign rt = instr[20:16];
  assign rd = instr[15:11];
  assign funct = instr[5:0];
  assign signImm = {{(`MIPS_XLEN-16){instr[15]}}, instr[15:0]};

  controlUnit uCtrl (
    .opcode(opcode),
    .funct(funct),
    .regWrite(regWrite),
    .regDst(regDst),
    .aluSrc(aluSrc),
    .branch(branch),
    .memWrite(memWrite),
    .memRead(memRead),
    .memToReg(memToReg),
    .aluCtrl(aluCtrl)
  );

  // ##################################################
  // datapath
  assign writeReg = regDst ? rd : rt;
  assign writeData = memToReg ? loadData : aluResult;
  assign srcB = aluSrc ? signImm : rdDataB;

  regFile uRegs (
    .clk(clk),
    .arstN(arstN),
    .rdAddrA(rs),
    .rdAddrB(rt),
    .rdDataA(rdDataA),
    .rdDataB(rdDataB),
    .wrEn(regWrite & ~stall), // commit only when the bus is done.
    .wrAddr(writeReg),
    .wrData(writeData)
  );

  alu uAlu (
    .a(rdDataA),
    .b(srcB),
    .aluCtrl(aluCtrl),
    .result(aluResult),
    .zero(zero)
  );

  wbDataPort uData (
    .clk(clk),
    .arstN(arstN),
    .memRead(memRead),
    .memWrite(memWrite),
    .addr(aluResult),
    .storeData(rdDataB),
    .stall(stall),
    .loadData(loadData),
    .wbCyc(wbCyc),
    .wbStb(wbStb),
    .wbWe(wbWe),
    .wbAdr(wbAdr),
    .wbDatW(wbDatW),
    .wbSel(wbSel),
    .wbDatR(wbDatR),
    .wbAck(wbAck)
  );

  // ##################################################
  // program counter
  assign pcPlus4 = pc + 32'd4;
  assign branchTarget = pcPlus4 + {signImm[`MIPS_XLEN-3:0], 2'b00};
  assign pcNext = (branch & zero) ? branchTarget : pcPlus4;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc <= '0;
    end else if (!stall) begin
      pc <= pcNext; // held while a bus cycle is open.
    end
  end

endmodule

/* design/wbDataPort.sv */
// wishbone classic master for single word accesses; ack must only come while stb is high.
`timescale 1ns/100ps
`include "mipsLite_defs.svh"

module wbDataPort import mipsLitePkg::*; (
  input logic clk,
  input logic arstN,
  input logic memRead,
  input logic memWrite,
  input word_t addr,
  input word_t storeData,
  output logic stall,
  output word_t loadData,
  output logic wbCyc,
  output logic wbStb,
  output logic wbWe,
  output word_t wbAdr,
  output word_t wbDatW,
  output logic [`MIPS_XLEN/8-1:0] wbSel,
  input word_t wbDatR,
  input logic wbAck
);

  busState_t state;
  busState_t stateNext;
  logic req;
  logic ackTaken;
  logic weQ;
  word_t adrQ;
  word_t datQ;

  assign req = memRead | memWrite;
  assign ackTaken = (state == busWait) & wbAck;

  // ##################################################
  // state machine
  always_comb begin
    stateNext = state;
    case (state)
      busIdle: if (req) stateNext = busWait;
      busWait: if (wbAck) stateNext = busIdle;
      default: stateNext = busIdle;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) state <= busIdle;
    else state <= stateNext;
  end

  // request fields held for the rest of the cycle.
  always_ff @(posedge clk) begin
    if ((state == busIdle) && req) begin
      adrQ <= addr;
      datQ <= storeData;
      weQ <= memWrite;
    end
  end

  // ##################################################
  // bus outputs
  assign wbCyc = (state == busWait) | req;
  assign wbStb = wbCyc;
  assign wbWe = (state == busWait) ? weQ : memWrite;
  assign wbAdr = (state == busWait) ? adrQ : addr;
  assign wbDatW = (state == busWait) ? datQ : storeData;
  assign wbSel = '1; // word accesses only.

  assign stall = req & ~ackTaken; // released in the ack cycle.
  assign loadData = wbDatR;

endmodule

/* design/regFile.sv */
// 2 combinational reads, 1 write at the rising edge; register 0 ignores writes and reads zero.
`timescale 1ns/100ps
`include "mipsLite_defs.svh"

module regFile import mipsLitePkg::*; (
  input logic clk,
  input logic arstN,
  input regAddr_t rdAddrA,
  input regAddr_t rdAddrB,
  output word_t rdDataA,
  output word_t rdDataB,
  input logic wrEn,
  input regAddr_t wrAddr,
  input word_t wrData
);

  word_t regs [`MIPS_NREGS];

  // ##################################################
  // write port
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < `MIPS_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && (wrAddr != '0)) begin
      regs[wrAddr] <= wrData;
    end
  end

  // read ports.
  assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
  assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

/* design/alu.sv */
// combinational 32-bit alu; slt compares signed, codes other than the five listed give zero.
`timescale 1ns/100ps
`include "mipsLite_defs.svh"

module alu import mipsLitePkg::*; (
  input word_t a,
  input word_t b,
  input aluCtrl_t aluCtrl,
  output word_t result,
  output logic zero
);

  word_t sum;
  word_t diff;
  logic lessThan;

  assign sum = a + b;
  assign diff = a - b;

  // signed compare from the subtraction and the operand signs.
  assign lessThan = (a[`MIPS_XLEN-1] != b[`MIPS_XLEN-1]) ? a[`MIPS_XLEN-1]
                                                          : diff[`MIPS_XLEN-1];

  // ##################################################
  // operation select
  always_comb begin
    case (aluCtrl)
      `MIPS_ALU_AND: result = a & b;
      `MIPS_ALU_OR: result = a | b;
      `MIPS_ALU_ADD: result = sum;
      `MIPS_ALU_SUB: result = diff;
      `MIPS_ALU_SLT: result = {{(`MIPS_XLEN-1){1'b0}}, lessThan};
      default: result = '0;
    endcase
  end

  assign zero = (result == '0); // used by beq.

endmodule

/* design/controlUnit.sv */
// combinational decode of lw, sw, beq and r-type add/sub/and/or/slt; anything else yields a no-op.
`timescale 1ns/100ps
`include "mipsLite_defs.svh"

module controlUnit import mipsLitePkg::*; (
  input opcode_t opcode,
  input funct_t funct,
  output logic regWrite,
  output logic regDst,
  output logic aluSrc,
  output logic branch,
  output logic memWrite,
  output logic memRead,
  output logic memToReg,
  output aluCtrl_t aluCtrl
);

  aluOp_t aluOp;
  logic mainRegWrite; // before the funct check.
  logic functValid;

  // ##################################################
  // main decoder
  always_comb begin
    mainRegWrite = 1'b0;
    regDst = 1'b0;
    aluSrc = 1'b0;
    branch = 1'b0;
    memWrite = 1'b0;
    memRead = 1'b0;
    memToReg = 1'b0;
    aluOp = 2'b00;
    case (opcode)
      `MIPS_OP_RTYPE: begin
        mainRegWrite = 1'b1;
        regDst = 1'b1;
        aluOp = 2'b10;
      end
      `MIPS_OP_LW: begin
        mainRegWrite = 1'b1;
        aluSrc = 1'b1;
        memRead = 1'b1;
        memToReg = 1'b1;
      end
      `MIPS_OP_SW: begin
        aluSrc = 1'b1;
        memWrite = 1'b1;
      end
      `MIPS_OP_BEQ: begin
        branch = 1'b1;
        aluOp = 2'b01;
      end
      default: begin
      end
    endcase
  end

  // ##################################################
  // alu decoder
  always_comb begin
    aluCtrl = `MIPS_ALU_ADD;
    functValid = 1'b1;
    case (aluOp)
      2'b00: aluCtrl = `MIPS_ALU_ADD; // address calculation.
      2'b01: aluCtrl = `MIPS_ALU_SUB; // compare for beq.
      2'b10: begin
        case (funct)
          `MIPS_FN_ADD: aluCtrl = `MIPS_ALU_ADD;
          `MIPS_FN_SUB: aluCtrl = `MIPS_ALU_SUB;
          `MIPS_FN_AND: aluCtrl = `MIPS_ALU_AND;
          `MIPS_FN_OR: aluCtrl = `MIPS_ALU_OR;
          `MIPS_FN_SLT: aluCtrl = `MIPS_ALU_SLT;
          default: functValid = 1'b0;
        endcase
      end
      default: aluCtrl = `MIPS_ALU_ADD;
    endcase
  end

  // unknown funct turns the r-type into a no-op.
  assign regWrite = mainRegWrite & functValid;

endmodule

/* design/mipsLitePkg.sv */
// shared types of the core; widths follow mipsLite_defs.svh, the register count must be a power of 2.
`include "mipsLite_defs.svh"

package mipsLitePkg;

  // ##################################################
  // datapath words and fields
  typedef logic [`MIPS_XLEN-1:0] word_t; // data or address word.

  typedef logic [$clog2(`MIPS_NREGS)-1:0] regAddr_t; // register index.

  typedef logic [5:0] opcode_t; // instr[31:26].

  typedef logic [5:0] funct_t; // instr[5:0].

  // ##################################################
  // control
  typedef logic [1:0] aluOp_t; // 00 add, 01 sub, 10 funct.

  typedef logic [2:0] aluCtrl_t;

  // data bus sequencing
  typedef enum logic {
    busIdle, // no cycle, or request raised this cycle.
    busWait // waiting for ack.
  } busState_t;

endpackage

/* design/mipsLite_defs.svh */
// word-only MIPS subset; opcodes and funct codes outside these lists decode as no-ops.
`ifndef MIPSLITE_DEFS_SVH
`define MIPSLITE_DEFS_SVH

// ##################################################
// widths
`define MIPS_XLEN 32 // data and address width.
`define MIPS_NREGS 32 // general purpose registers.

// ##################################################
// opcodes and funct codes
`define MIPS_OP_RTYPE 6'b000000
`define MIPS_OP_LW 6'b100011
`define MIPS_OP_SW 6'b101011
`define MIPS_OP_BEQ 6'b000100

`define MIPS_FN_ADD 6'b100000
`define MIPS_FN_SUB 6'b100010
`define MIPS_FN_AND 6'b100100
`define MIPS_FN_OR 6'b100101
`define MIPS_FN_SLT 6'b101010

// ##################################################
// alu control
`define MIPS_ALU_AND 3'b000
`define MIPS_ALU_OR 3'b001
`define MIPS_ALU_ADD 3'b010
`define MIPS_ALU_SUB 3'b110
`define MIPS_ALU_SLT 3'b111

`endif
